/* project.f */
rtl/pim_bus_pkg.sv
rtl/pim_flash_pkg.sv
rtl/pim_bus_decode.sv
rtl/pim_mode_fsm.sv
rtl/pim_pulse_engine.sv
rtl/pim_ctrl_top.sv
bench/pim_ctrl_checker.sv
bench/tb_pim_ctrl.sv

/* bench/tb_pim_ctrl.sv */
`timescale 1ns/1ps

module tb_pim_ctrl;

    import pim_bus_pkg::*;
    import pim_flash_pkg::*;

    localparam int unsigned READ_CYCLES  = 9;
    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_RANDOM   = 24;
    localparam int          NUM_CMDS     = NUM_RANDOM + 6;
    // writes plus handshake plus the longest pulse train or read window
    localparam int          WORST_CMD    = 16 + 4 * 7 + READ_CYCLES;
    localparam int          TIMEOUT_NS   =
        (RESET_CYCLES + NUM_CMDS * WORST_CMD + 100) * CLK_PERIOD;

    logic        clk_i;
    logic        rst_ni;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    flash_drv_t  flash;
    logic        busy;
    int          err_cnt;
    int          cmd_cnt;

    pim_ctrl_top #(
        .READ_CYCLES (READ_CYCLES)
    ) u_pim_ctrl_top (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .flash_o     (flash),
        .busy_o      (busy)
    );

    pim_ctrl_checker #(
        .READ_CYCLES (READ_CYCLES)
    ) u_checker (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .flash_i     (flash),
        .busy_i      (busy),
        .err_cnt_o   (err_cnt)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // one write cycle, called on a falling edge
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        bus_addr  = addr;
        bus_wdata = data;
        @(negedge clk_i);
        bus_addr  = '0;
        bus_wdata = '0;
    endtask

    function automatic logic [31:0] target_addr(input row_t row, input col_t col);
        return {PERIPH_TAG, 4'h0, row, col};
    endfunction

    function automatic logic [31:0] pulse_word(input pulse_width_t w, input pulse_count_t c);
        return {10'd0, w, c};
    endfunction

    task automatic wait_until_idle();
        while (busy) @(negedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic run_command(input logic [2:0] code, input row_t row, input col_t col,
                               input pulse_width_t w, input pulse_count_t c);
        bus_write(STATUS_ADDR, 32'd0);
        bus_write(MODE_ADDR, {29'd0, code});
        bus_write(target_addr(row, col), pulse_word(w, c));
        wait_until_idle();
        cmd_cnt++;
    endtask

    // bad codes and early target writes, then recovery with a read
    task automatic send_rejected_writes();
        logic [2:0] bad_codes [5];
        bad_codes = '{3'd0, 3'd4, 3'd5, 3'd6, 3'd7};
        bus_write(target_addr(7'h11, 9'h022), pulse_word(17'd2, 5'd2));  // still idle
        bus_write(STATUS_ADDR, 32'd0);
        bus_write(target_addr(7'h12, 9'h033), pulse_word(17'd3, 5'd1));  // no mode yet
        for (int i = 0; i < 5; i++) begin
            bus_write(MODE_ADDR, {29'd0, bad_codes[i]});
            bus_write(target_addr(7'h13, 9'h044), pulse_word(17'd1, 5'd3));
        end
        bus_write(STATUS_ADDR, 32'd0);  // ignored while armed
        repeat (3) @(negedge clk_i);
        bus_write(MODE_ADDR, {29'd0, OP_READ});
        bus_write(target_addr(7'h5a, 9'h155), 32'd0);
        wait_until_idle();
        cmd_cnt++;
    endtask

    task automatic random_command();
        logic [2:0]   code;
        row_t         row;
        col_t         col;
        pulse_width_t w;
        pulse_count_t c;
        code = 3'($urandom_range(3, 1));
        row  = 7'($urandom_range(127, 0));
        col  = 9'($urandom_range(511, 0));
        w    = 17'($urandom_range(6, 0));
        c    = 5'($urandom_range(4, 0));
        run_command(code, row, col, w, c);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, a command never finished", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        cmd_cnt   = 0;
        void'($urandom(32'h0cae_f26c));
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (3) @(negedge clk_i);

        run_command(OP_ERASE, 7'h15, 9'h0a3, 17'd3, 5'd2);
        run_command(OP_PROGRAM, 7'h7f, 9'h1ff, 17'd2, 5'd3);
        run_command(OP_READ, 7'h01, 9'h100, 17'd0, 5'd0);
        run_command(OP_ERASE, 7'h22, 9'h011, 17'd5, 5'd0);    // zero count
        run_command(OP_PROGRAM, 7'h33, 9'h022, 17'd0, 5'd4);  // zero width
        send_rejected_writes();
        repeat (NUM_RANDOM) random_command();

        repeat (4) @(negedge clk_i);
        $display("%0d commands, %0d errors", cmd_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/pim_ctrl_checker.sv */
`timescale 1ns/1ps

module pim_ctrl_checker #(
    parameter int unsigned READ_CYCLES = 9
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [31:0]               bus_addr_i,
    input  logic [31:0]               bus_wdata_i,
    input  pim_flash_pkg::flash_drv_t flash_i,
    input  logic                      busy_i,
    output int                        err_cnt_o
);

    import pim_bus_pkg::*;
    import pim_flash_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ARMED,
        M_READY,
        M_EXEC
    } model_e;

    model_e       m_state;
    pim_op_e      m_op;
    row_t         m_row;
    col_t         m_col;
    pulse_width_t m_width;
    pulse_count_t m_count;
    int unsigned  since_q;     // edges since the target write
    int unsigned  period;
    int unsigned  last_offs;   // offset of the done cycle
    flash_drv_t   exp_flash;
    logic         exp_busy;
    logic         code_ok;
    int           err_cnt;

    initial err_cnt = 0;
    assign err_cnt_o = err_cnt;

    task automatic log_mismatch(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        err_cnt++;
        $display("FAILED %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
    endtask

    task automatic log_failure(input string what);
        err_cnt++;
        $display("error at %0t: %s", $time, what);
    endtask

    assign code_ok   = (bus_wdata_i[2:0] >= 3'd1) && (bus_wdata_i[2:0] <= 3'd3);
    assign period    = int'(m_width) + 1;
    assign last_offs = (m_op == OP_READ) ? READ_CYCLES : int'(m_count) * period;
    assign exp_busy  = (m_state == M_READY) || (m_state == M_EXEC);

    // reference protocol, one command at a time
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_state <= M_IDLE;
            m_op    <= OP_NONE;
            m_row   <= '0;
            m_col   <= '0;
            m_width <= '0;
            m_count <= '0;
            since_q <= 0;
        end else begin
            case (m_state)
                M_IDLE: if (bus_addr_i == STATUS_ADDR) m_state <= M_ARMED;
                M_ARMED: begin
                    if (bus_addr_i == MODE_ADDR && code_ok) begin
                        m_state <= M_READY;
                        m_op    <= pim_op_e'(bus_wdata_i[2:0]);
                    end
                end
                M_READY: begin
                    if (bus_addr_i[31:20] == PERIPH_TAG) begin
                        m_state <= M_EXEC;
                        m_row   <= bus_addr_i[15:9];
                        m_col   <= bus_addr_i[8:0];
                        m_width <= bus_wdata_i[21:5];
                        m_count <= bus_wdata_i[4:0];
                        since_q <= 0;
                    end
                end
                default: begin
                    since_q <= since_q + 1;
                    if (since_q == last_offs + 1) begin  // done seen, back to idle
                        m_state <= M_IDLE;
                        m_op    <= OP_NONE;
                    end
                end
            endcase
        end
    end

    // expected pins, first enable two edges after the target write
    always_comb begin
        int unsigned offs;
        exp_flash = '0;
        offs = since_q - 1;
        if (m_state == M_EXEC && since_q != 0) begin
            if (m_op == OP_READ) begin
                if (offs < READ_CYCLES) begin
                    exp_flash.read_en  = 1'b1;
                    exp_flash.row_addr = m_row;
                    exp_flash.col_addr = m_col;
                    exp_flash.exec_cnt = exec_cnt_t'(READ_CYCLES - offs);
                end
            end else if (offs < last_offs && (offs % period) < m_width) begin
                exp_flash.row_addr = m_row;
                if (m_op == OP_ERASE) begin
                    exp_flash.erase_en = 1'b1;
                end else begin
                    exp_flash.program_en = 1'b1;
                    exp_flash.col_addr   = m_col;
                end
            end
        end
    end

    a_erase_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_i.erase_en == exp_flash.erase_en)
        else log_mismatch("erase_en", $sampled(exp_flash.erase_en), $sampled(flash_i.erase_en));

    a_program_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_i.program_en == exp_flash.program_en)
        else log_mismatch("program_en", $sampled(exp_flash.program_en),
                          $sampled(flash_i.program_en));

    a_read_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_i.read_en == exp_flash.read_en)
        else log_mismatch("read_en", $sampled(exp_flash.read_en), $sampled(flash_i.read_en));

    a_row_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_i.row_addr == exp_flash.row_addr)
        else log_mismatch("row_addr", $sampled(exp_flash.row_addr), $sampled(flash_i.row_addr));

    a_col_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_i.col_addr == exp_flash.col_addr)
        else log_mismatch("col_addr", $sampled(exp_flash.col_addr), $sampled(flash_i.col_addr));

    a_exec_cnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_i.exec_cnt == exp_flash.exec_cnt)
        else log_mismatch("exec_cnt", $sampled(exp_flash.exec_cnt), $sampled(flash_i.exec_cnt));

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        busy_i == exp_busy)
        else log_mismatch("busy_o", $sampled(exp_busy), $sampled(busy_i));

    a_one_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({flash_i.erase_en, flash_i.program_en, flash_i.read_en}))
        else log_failure("more than one flash enable high in the same cycle");

    a_quiet_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !busy_i |-> (flash_i == '0))
        else log_failure("flash outputs driven while busy_o is low");

endmodule

/* rtl/pim_ctrl_top.sv */
`timescale 1ns/1ps

module pim_ctrl_top #(
    parameter int unsigned READ_CYCLES = 9  // read window length, 1..15
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [31:0]               bus_addr_i,
    input  logic [31:0]               bus_wdata_i,
    output pim_flash_pkg::flash_drv_t flash_o,
    output logic                      busy_o
);

    import pim_bus_pkg::*;
    import pim_flash_pkg::*;

    bus_write_t wr;
    pim_op_t    op;
    logic       start;
    logic       done;

    pim_bus_decode u_bus_decode (
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .wr_o        (wr)
    );

    pim_mode_fsm u_mode_fsm (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .wr_i    (wr),
        .done_i  (done),
        .start_o (start),
        .op_o    (op),
        .busy_o  (busy_o)
    );

    pim_pulse_engine #(
        .READ_CYCLES (READ_CYCLES)
    ) u_pulse_engine (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (start),
        .op_i    (op),
        .done_o  (done),
        .flash_o (flash_o)
    );

endmodule

/* rtl/pim_pulse_engine.sv */
`timescale 1ns/1ps

module pim_pulse_engine #(
    parameter int unsigned READ_CYCLES = 9
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      start_i,
    input  pim_flash_pkg::pim_op_t    op_i,
    output logic                      done_o,
    output pim_flash_pkg::flash_drv_t flash_o
);

    import pim_bus_pkg::*;
    import pim_flash_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_HIGH,  // enable asserted
        PH_GAP,   // low cycle after a pulse
        PH_DONE
    } phase_e;

    phase_e       phase_q;
    phase_e       phase_d;
    phase_e       pulse_phase;
    pulse_width_t width_q;   // high cycles left in this pulse
    pulse_width_t width_d;
    pulse_count_t count_q;   // pulses left, current one included
    pulse_count_t count_d;
    exec_cnt_t    rd_cnt_q;
    exec_cnt_t    rd_cnt_d;
    logic         erase_q;   // registered enables
    logic         program_q;
    logic         read_q;
    logic         is_read;
    logic         en_high;

    assign is_read = (op_i.op == OP_READ);

    // a zero width degenerates into a gap only
    assign pulse_phase = (op_i.width == '0) ? PH_GAP : PH_HIGH;

    always_comb begin
        phase_d  = phase_q;
        width_d  = width_q;
        count_d  = count_q;
        rd_cnt_d = rd_cnt_q;
        case (phase_q)
            PH_IDLE: begin
                if (start_i) begin
                    if (is_read) begin
                        phase_d  = PH_HIGH;
                        rd_cnt_d = exec_cnt_t'(READ_CYCLES);
                    end else if (op_i.count == '0) begin
                        phase_d = PH_DONE;
                    end else begin
                        phase_d = pulse_phase;
                        width_d = op_i.width;
                        count_d = op_i.count;
                    end
                end
            end
            PH_HIGH: begin
                if (is_read) begin
                    if (rd_cnt_q > 4'd1) begin
                        rd_cnt_d = rd_cnt_q - 4'd1;
                    end else begin
                        phase_d = PH_DONE;
                    end
                end else if (width_q > 17'd1) begin
                    width_d = width_q - 17'd1;
                end else begin
                    phase_d = PH_GAP;
                end
            end
            PH_GAP: begin
                if (count_q > 5'd1) begin
                    count_d = count_q - 5'd1;
                    width_d = op_i.width;  // reload for the next pulse
                    phase_d = pulse_phase;
                end else begin
                    phase_d = PH_DONE;
                end
            end
            default: phase_d = PH_IDLE;  // PH_DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q   <= PH_IDLE;
            width_q   <= '0;
            count_q   <= '0;
            rd_cnt_q  <= '0;
            erase_q   <= 1'b0;
            program_q <= 1'b0;
            read_q    <= 1'b0;
        end else begin
            phase_q   <= phase_d;
            width_q   <= width_d;
            count_q   <= count_d;
            rd_cnt_q  <= rd_cnt_d;
            erase_q   <= (phase_d == PH_HIGH) && (op_i.op == OP_ERASE);
            program_q <= (phase_d == PH_HIGH) && (op_i.op == OP_PROGRAM);
            read_q    <= (phase_d == PH_HIGH) && is_read;
        end
    end

    assign en_high = (phase_q == PH_HIGH);
    assign done_o  = (phase_q == PH_DONE);

    // addresses only visible during the high phase
    always_comb begin
        flash_o            = '0;
        flash_o.erase_en   = erase_q;
        flash_o.program_en = program_q;
        flash_o.read_en    = read_q;
        if (en_high) begin
            flash_o.row_addr = op_i.row;
            if (op_i.op != OP_ERASE) begin
                flash_o.col_addr = op_i.col;  // erase is row wide
            end
            if (is_read) begin
                flash_o.exec_cnt = rd_cnt_q;
            end
        end
    end

    a_one_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({flash_o.erase_en, flash_o.program_en, flash_o.read_en}))
        else $error("more than one flash enable high");

    a_row_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(flash_o.erase_en || flash_o.program_en || flash_o.read_en)
            |-> (flash_o.row_addr == '0))
        else $error("row_addr driven with no enable");

endmodule

/* rtl/pim_mode_fsm.sv */
`timescale 1ns/1ps

module pim_mode_fsm (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  pim_bus_pkg::bus_write_t wr_i,
    input  logic                    done_i,
    output logic                    start_o,
    output pim_flash_pkg::pim_op_t  op_o,
    output logic                    busy_o
);

    import pim_flash_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    pim_op_e     mode_q;   // mode register
    pim_op_t     op_q;
    logic        start_q;
    logic        mode_ok;
    logic        fire;
    logic        finish;

    // only erase, program and read are accepted
    assign mode_ok = wr_i.is_mode &&
                     (wr_i.mode_code inside {OP_ERASE, OP_PROGRAM, OP_READ});

    assign fire   = (state_q == ST_MODE_READY) && wr_i.is_target;
    assign finish = (state_q == ST_MODE_EXEC) && done_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_i.is_status) begin
                    state_d = ST_WAIT_MODE;
                end
            end
            ST_WAIT_MODE: begin
                if (mode_ok) begin
                    state_d = ST_MODE_READY;
                end
            end
            ST_MODE_READY: begin
                if (fire) begin
                    state_d = ST_MODE_EXEC;
                end
            end
            ST_MODE_EXEC: begin
                if (finish) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            mode_q  <= OP_NONE;
            op_q    <= '0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= fire;  // start follows the target write by one cycle

            if (state_q == ST_WAIT_MODE && mode_ok) begin
                mode_q <= pim_op_e'(wr_i.mode_code);
            end

            if (fire) begin
                op_q.op    <= mode_q;
                op_q.row   <= wr_i.row;
                op_q.col   <= wr_i.col;
                op_q.width <= wr_i.width;
                op_q.count <= wr_i.count;
            end

            if (finish) begin
                mode_q <= OP_NONE;
                op_q   <= '0;
            end
        end
    end

    assign start_o = start_q;
    assign op_o    = op_q;
    assign busy_o  = (mode_q != OP_NONE);

    // engine sees a stable operation for the whole command
    a_op_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $changed(op_o) |-> start_o || (state_q == ST_IDLE))
        else $error("op_o changed outside start or return to idle");

    a_idle_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == ST_IDLE) |-> !busy_o)
        else $error("busy_o high while idle");

endmodule

/* rtl/pim_bus_decode.sv */
`timescale 1ns/1ps

module pim_bus_decode (
    input  logic [31:0]             bus_addr_i,
    input  logic [31:0]             bus_wdata_i,
    output pim_bus_pkg::bus_write_t wr_o
);

    import pim_bus_pkg::*;

    logic hit_status;
    logic hit_mode;
    logic hit_target;

    // the only address compares in the design
    assign hit_status = (bus_addr_i == STATUS_ADDR);
    assign hit_mode   = (bus_addr_i == MODE_ADDR);
    assign hit_target = (bus_addr_i[31:20] == PERIPH_TAG);

    always_comb begin
        wr_o.is_status = hit_status;
        wr_o.is_mode   = hit_mode;
        wr_o.is_target = hit_target;

        // mode code sits in the low data bits of a MODE write
        wr_o.mode_code = bus_wdata_i[2:0];

        // target location comes from the address
        wr_o.row = row_t'(bus_addr_i[15:9]);
        wr_o.col = col_t'(bus_addr_i[8:0]);

        // pulse parameters come from the data word
        wr_o.width = pulse_width_t'(bus_wdata_i[21:5]);
        wr_o.count = pulse_count_t'(bus_wdata_i[4:0]);
    end

endmodule

/* rtl/pim_flash_pkg.sv */
package pim_flash_pkg;

    // mode codes as written to MODE_ADDR
    // 4..6 were parallel, row-by-row and load, not supported here
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_ERASE   = 3'd1,
        OP_PROGRAM = 3'd2,
        OP_READ    = 3'd3
    } pim_op_e;

    typedef enum logic [1:0] {
        ST_IDLE       = 2'b00,
        ST_WAIT_MODE  = 2'b01,
        ST_MODE_READY = 2'b10,
        ST_MODE_EXEC  = 2'b11
    } ctrl_state_e;

    typedef logic [3:0] exec_cnt_t;  // read window counter

    // operation handed from the command FSM to the pulse engine
    typedef struct packed {
        pim_op_e                   op;
        pim_bus_pkg::row_t         row;
        pim_bus_pkg::col_t         col;
        pim_bus_pkg::pulse_width_t width;
        pim_bus_pkg::pulse_count_t count;
    } pim_op_t;

    // flash macro driver pins
    typedef struct packed {
        logic              erase_en;
        logic              program_en;
        logic              read_en;
        pim_bus_pkg::row_t row_addr;
        pim_bus_pkg::col_t col_addr;
        exec_cnt_t         exec_cnt;
    } flash_drv_t;

endpackage

/* rtl/pim_bus_pkg.sv */
package pim_bus_pkg;

    // peripheral address map
    localparam logic [31:0] STATUS_ADDR = 32'h4200_0000;  // arms the controller
    localparam logic [31:0] MODE_ADDR   = 32'h4100_0000;  // selects the operation
    localparam logic [11:0] PERIPH_TAG  = 12'h400;        // addr[31:20] of a target write

    // fields of the target write
    typedef logic [6:0]  row_t;          // addr[15:9]
    typedef logic [8:0]  col_t;          // addr[8:0]
    typedef logic [16:0] pulse_width_t;  // data[21:5]
    typedef logic [4:0]  pulse_count_t;  // data[4:0]

    // one bus write, already classified and sliced
    typedef struct packed {
        logic         is_status;
        logic         is_mode;
        logic         is_target;
        logic [2:0]   mode_code;
        row_t         row;
        col_t         col;
        pulse_width_t width;
        pulse_count_t count;
    } bus_write_t;

endpackage
